// File: Bender.yml
package:
  name: matrix_calculator

sources:
  - include_dirs:
      - src
    files:
      - src/matrix_calc_pkg.sv
      - src/button_debounce.sv
      - src/mode_controller.sv
      - src/matrix_manager.sv
      - src/element_ram.sv
      - src/matrix_entry.sv
      - src/matrix_readout.sv
      - src/status_display.sv
      - src/matrix_calculator_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - tests/matrix_calculator_tb.sv

// File: matrix_calculator_top.f
+incdir+src
src/matrix_calc_pkg.sv
src/button_debounce.sv
src/mode_controller.sv
src/matrix_manager.sv
src/element_ram.sv
src/matrix_entry.sv
src/matrix_readout.sv
src/status_display.sv
src/matrix_calculator_top.sv
tests/matrix_calculator_tb.sv

// File: src/button_debounce.sv
// =========================================================
// Button synchronizer and single pulse debouncer
// =========================================================
`timescale 1ns/1ps
`include "matrix_calc_defines.svh"

module button_debounce (
    input  logic clk,
    input  logic rst_n,
    input  logic btn_in,
    output logic btn_pulse
);

    localparam int CNT_W = $clog2(`DEBOUNCE_CYCLES + 1);

    logic [1:0]       sync;
    logic [CNT_W-1:0] stable_cnt;
    logic             fired;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync       <= 2'b00;
            stable_cnt <= '0;
            fired      <= 1'b0;
            btn_pulse  <= 1'b0;
        end else begin
            sync      <= {sync[0], btn_in};
            btn_pulse <= 1'b0;
            if (!sync[1]) begin
                // Released, so the next press may fire again
                stable_cnt <= '0;
                fired      <= 1'b0;
            end else if (!fired) begin
                if (stable_cnt == CNT_W'(`DEBOUNCE_CYCLES - 1)) begin
                    btn_pulse <= 1'b1;
                    fired     <= 1'b1;
                end else begin
                    stable_cnt <= stable_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// File: src/element_ram.sv
// =========================================================
// Simple dual-port element memory, registered read
// =========================================================
`timescale 1ns/1ps
`include "matrix_calc_defines.svh"

module element_ram (
    input  logic                   clk,
    input  logic                   wr_en,
    input  matrix_calc_pkg::addr_t wr_addr,
    input  matrix_calc_pkg::elem_t wr_data,
    input  logic                   rd_en,
    input  matrix_calc_pkg::addr_t rd_addr,
    output matrix_calc_pkg::elem_t rd_data
);

    import matrix_calc_pkg::*;

    elem_t mem [`MAX_ELEMENTS];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// File: src/matrix_calc_defines.svh
// =========================================================
// Fixed limits, widths, debounce length and hold timer
// scaling for the matrix store
// =========================================================
`ifndef MATRIX_CALC_DEFINES_SVH
`define MATRIX_CALC_DEFINES_SVH

// Matrix limits
`define MAX_DIM 5
`define MAX_VALUE 9
`define MAX_SLOTS 4

// Element storage
`define MAX_ELEMENTS 64
`define ADDR_WIDTH 6
`define ELEM_WIDTH 4

// Buttons and error hold timer
`define DEBOUNCE_CYCLES 4
`define TICKS_PER_SECOND 16
`define HOLD_SECONDS 7

`endif

// File: src/matrix_calc_pkg.sv
// =========================================================
// Mode, error and field types shared by all blocks
// =========================================================
`include "matrix_calc_defines.svh"

package matrix_calc_pkg;

    // Top level operating mode
    typedef enum logic [1:0] {
        MODE_MENU,
        MODE_ENTRY,
        MODE_READOUT
    } mode_t;

    // Error raised by the active mode block
    typedef enum logic [2:0] {
        ERR_NONE,
        ERR_DIM,
        ERR_VALUE,
        ERR_FULL,
        ERR_EMPTY
    } err_t;

    // Row or column count
    typedef logic [2:0] dim_t;

    typedef logic [1:0] slot_t;

    typedef logic [`ADDR_WIDTH-1:0] addr_t;

    typedef logic [`ELEM_WIDTH-1:0] elem_t;

endpackage

// File: src/matrix_calculator_top.sv
// =========================================================
// Matrix store top: debouncers, mode control, slot table,
// element memory, entry, readout and status display
// =========================================================
`timescale 1ns/1ps

module matrix_calculator_top (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [2:0] dip_sw,
    input  logic       btn_confirm,
    input  logic       btn_back,
    input  logic [7:0] rx_data,
    input  logic       rx_done,
    input  logic       tx_busy,
    output logic [7:0] tx_data,
    output logic       tx_start,
    output logic [6:0] seg_mode,
    output logic [6:0] seg_countdown,
    output logic [3:0] led_status
);

    import matrix_calc_pkg::*;

    logic       confirm_pulse;
    logic       back_pulse;
    mode_t      mode;
    logic       entry_active;
    logic       readout_active;
    err_t       entry_err;
    err_t       readout_err;
    logic       error_active;
    logic [3:0] countdown;
    logic       error_timeout;

    // Slot table
    logic  alloc_req;
    dim_t  alloc_m;
    dim_t  alloc_n;
    logic  alloc_done;
    logic  alloc_ok;
    slot_t alloc_slot;
    addr_t alloc_addr;
    logic  commit_req;
    slot_t query_slot;
    logic  query_valid;
    dim_t  query_m;
    dim_t  query_n;
    addr_t query_addr;

    // Element memory
    logic  wr_en;
    addr_t wr_addr;
    elem_t wr_data;
    logic  rd_en;
    addr_t rd_addr;
    elem_t rd_data;

    assign entry_active   = (mode == MODE_ENTRY);
    assign readout_active = (mode == MODE_READOUT);

    button_debounce u_db_confirm (
        .clk, .rst_n,
        .btn_in    (btn_confirm),
        .btn_pulse (confirm_pulse)
    );

    button_debounce u_db_back (
        .clk, .rst_n,
        .btn_in    (btn_back),
        .btn_pulse (back_pulse)
    );

    mode_controller u_mode_ctrl (
        .clk, .rst_n, .confirm_pulse, .back_pulse, .dip_sw,
        .entry_err, .readout_err, .mode,
        .error_active, .countdown, .error_timeout
    );

    matrix_manager u_manager (
        .clk, .rst_n,
        .alloc_req, .alloc_m, .alloc_n,
        .alloc_done, .alloc_ok, .alloc_slot, .alloc_addr,
        .commit_req,
        .query_slot, .query_valid, .query_m, .query_n, .query_addr
    );

    element_ram u_ram (
        .clk, .wr_en, .wr_addr, .wr_data, .rd_en, .rd_addr, .rd_data
    );

    matrix_entry u_entry (
        .clk, .rst_n,
        .active (entry_active),
        .error_timeout, .rx_data, .rx_done,
        .alloc_req, .alloc_m, .alloc_n,
        .alloc_done, .alloc_ok, .alloc_slot, .alloc_addr,
        .commit_req, .wr_en, .wr_addr, .wr_data,
        .err    (entry_err)
    );

    matrix_readout u_readout (
        .clk, .rst_n,
        .active (readout_active),
        .error_timeout, .confirm_pulse, .dip_sw,
        .query_slot, .query_valid, .query_m, .query_n, .query_addr,
        .rd_en, .rd_addr, .rd_data,
        .tx_data, .tx_start, .tx_busy,
        .err    (readout_err)
    );

    status_display u_status (
        .mode, .error_active, .countdown,
        .seg_mode, .seg_countdown, .led_status
    );

endmodule

// File: src/matrix_entry.sv
// =========================================================
// Matrix entry from the received byte stream: dimensions,
// limit checks, allocation, element writes and commit
// =========================================================
`timescale 1ns/1ps
`include "matrix_calc_defines.svh"

module matrix_entry (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   active,
    input  logic                   error_timeout,
    input  logic [7:0]             rx_data,
    input  logic                   rx_done,
    output logic                   alloc_req,
    output matrix_calc_pkg::dim_t  alloc_m,
    output matrix_calc_pkg::dim_t  alloc_n,
    input  logic                   alloc_done,
    input  logic                   alloc_ok,
    input  matrix_calc_pkg::slot_t alloc_slot,
    input  matrix_calc_pkg::addr_t alloc_addr,
    output logic                   commit_req,
    output logic                   wr_en,
    output matrix_calc_pkg::addr_t wr_addr,
    output matrix_calc_pkg::elem_t wr_data,
    output matrix_calc_pkg::err_t  err
);

    import matrix_calc_pkg::*;

    typedef enum logic [2:0] {
        S_GET_M,
        S_GET_N,
        S_ALLOC,
        S_DATA,
        S_COMMIT,
        S_ERR
    } state_t;

    state_t     state;
    addr_t      base;
    logic [5:0] elem_idx;
    logic [5:0] elem_total;
    logic       dim_bad;

    assign elem_total = alloc_m * alloc_n;
    assign dim_bad    = (rx_data == 8'd0) || (rx_data > `MAX_DIM);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= S_GET_M;
            err        <= ERR_NONE;
            alloc_req  <= 1'b0;
            commit_req <= 1'b0;
            wr_en      <= 1'b0;
            elem_idx   <= '0;
        end else begin
            alloc_req  <= 1'b0;
            commit_req <= 1'b0;
            wr_en      <= 1'b0;
            if (!active || error_timeout) begin
                state <= S_GET_M;
                err   <= ERR_NONE;
            end else begin
                case (state)
                    S_GET_M, S_GET_N: begin
                        if (rx_done && dim_bad) begin
                            err   <= ERR_DIM;
                            state <= S_ERR;
                        end else if (rx_done && state == S_GET_M) begin
                            state <= S_GET_N;
                        end else if (rx_done) begin
                            alloc_req <= 1'b1;
                            state     <= S_ALLOC;
                        end
                    end
                    S_ALLOC: begin
                        if (alloc_done && alloc_ok) begin
                            elem_idx <= '0;
                            state    <= S_DATA;
                        end else if (alloc_done) begin
                            err   <= ERR_FULL;
                            state <= S_ERR;
                        end
                    end
                    S_DATA: begin
                        // Any bad element abandons the matrix uncommitted
                        if (rx_done && rx_data > `MAX_VALUE) begin
                            err   <= ERR_VALUE;
                            state <= S_ERR;
                        end else if (rx_done) begin
                            wr_en    <= 1'b1;
                            elem_idx <= elem_idx + 1'b1;
                            if (elem_idx == elem_total - 1'b1) begin
                                state <= S_COMMIT;
                            end
                        end
                    end
                    S_COMMIT: begin
                        commit_req <= 1'b1;
                        state      <= S_GET_M;
                    end
                    default: begin
                        // Error held until the timer releases it
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_done && state == S_GET_M) begin
            alloc_m <= dim_t'(rx_data);
        end
        if (rx_done && state == S_GET_N) begin
            alloc_n <= dim_t'(rx_data);
        end
        if (alloc_done && state == S_ALLOC) begin
            base <= alloc_addr;
        end
        if (rx_done && state == S_DATA) begin
            wr_addr <= base + addr_t'(elem_idx);
            wr_data <= rx_data[`ELEM_WIDTH-1:0];
        end
    end

endmodule

// File: src/matrix_manager.sv
// =========================================================
// Slot table for stored matrices: allocate, commit and
// combinational query
// =========================================================
`timescale 1ns/1ps
`include "matrix_calc_defines.svh"

module matrix_manager (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   alloc_req,
    input  matrix_calc_pkg::dim_t  alloc_m,
    input  matrix_calc_pkg::dim_t  alloc_n,
    output logic                   alloc_done,
    output logic                   alloc_ok,
    output matrix_calc_pkg::slot_t alloc_slot,
    output matrix_calc_pkg::addr_t alloc_addr,
    input  logic                   commit_req,
    input  matrix_calc_pkg::slot_t query_slot,
    output logic                   query_valid,
    output matrix_calc_pkg::dim_t  query_m,
    output matrix_calc_pkg::dim_t  query_n,
    output matrix_calc_pkg::addr_t query_addr
);

    import matrix_calc_pkg::*;

    localparam int CNT_W = $clog2(`MAX_SLOTS + 1);

    dim_t                  slot_m    [`MAX_SLOTS];
    dim_t                  slot_n    [`MAX_SLOTS];
    addr_t                 slot_addr [`MAX_SLOTS];
    logic [`MAX_SLOTS-1:0] slot_valid;
    logic [CNT_W-1:0]      total_count;
    logic [`ADDR_WIDTH:0]  free_ptr;
    logic [`ADDR_WIDTH:0]  need;
    logic [`ADDR_WIDTH:0]  pend_need;
    dim_t                  pend_m;
    dim_t                  pend_n;
    logic                  fits;

    assign need      = alloc_m * alloc_n;
    assign pend_need = pend_m * pend_n;
    assign fits      = (total_count < `MAX_SLOTS) && (free_ptr + need <= `MAX_ELEMENTS);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alloc_done  <= 1'b0;
            alloc_ok    <= 1'b0;
            slot_valid  <= '0;
            total_count <= '0;
            free_ptr    <= '0;
        end else begin
            alloc_done <= alloc_req;
            if (alloc_req) begin
                alloc_ok <= fits;
            end
            // Slots fill in order and are never freed
            if (commit_req) begin
                slot_valid[alloc_slot] <= 1'b1;
                total_count            <= total_count + 1'b1;
                free_ptr               <= free_ptr + pend_need;
            end
        end
    end

    // Pending allocation, held until the commit
    always_ff @(posedge clk) begin
        if (alloc_req) begin
            alloc_slot <= slot_t'(total_count);
            alloc_addr <= addr_t'(free_ptr);
            pend_m     <= alloc_m;
            pend_n     <= alloc_n;
        end
        if (commit_req) begin
            slot_m[alloc_slot]    <= pend_m;
            slot_n[alloc_slot]    <= pend_n;
            slot_addr[alloc_slot] <= alloc_addr;
        end
    end

    assign query_valid = slot_valid[query_slot];
    assign query_m     = slot_m[query_slot];
    assign query_n     = slot_n[query_slot];
    assign query_addr  = slot_addr[query_slot];

endmodule

// File: src/matrix_readout.sv
// =========================================================
// Matrix readout as a transmitted byte stream: m, n, then
// the elements in row-major order
// =========================================================
`timescale 1ns/1ps
`include "matrix_calc_defines.svh"

module matrix_readout (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   active,
    input  logic                   error_timeout,
    input  logic                   confirm_pulse,
    input  logic [2:0]             dip_sw,
    output matrix_calc_pkg::slot_t query_slot,
    input  logic                   query_valid,
    input  matrix_calc_pkg::dim_t  query_m,
    input  matrix_calc_pkg::dim_t  query_n,
    input  matrix_calc_pkg::addr_t query_addr,
    output logic                   rd_en,
    output matrix_calc_pkg::addr_t rd_addr,
    input  matrix_calc_pkg::elem_t rd_data,
    output logic [7:0]             tx_data,
    output logic                   tx_start,
    input  logic                   tx_busy,
    output matrix_calc_pkg::err_t  err
);

    import matrix_calc_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_HDR_M,
        S_HDR_N,
        S_LOAD,
        S_ELEM,
        S_ERR
    } state_t;

    state_t     state;
    dim_t       n_q;
    addr_t      base;
    logic [5:0] elem_total;
    logic [5:0] rd_idx;
    logic [7:0] tx_byte;
    logic       sending;

    assign query_slot = slot_t'(dip_sw);
    assign sending    = (state == S_HDR_M) || (state == S_HDR_N) || (state == S_ELEM);
    assign tx_start   = sending && !tx_busy;
    assign tx_data    = tx_byte;

    // Next element is read while the current byte is accepted
    assign rd_en   = tx_start && (state == S_HDR_N || (state == S_ELEM && rd_idx != elem_total));
    assign rd_addr = base + addr_t'(rd_idx);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= S_IDLE;
            err    <= ERR_NONE;
            rd_idx <= '0;
        end else if (!active || error_timeout) begin
            state <= S_IDLE;
            err   <= ERR_NONE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (confirm_pulse && (dip_sw >= `MAX_SLOTS || !query_valid)) begin
                        err   <= ERR_EMPTY;
                        state <= S_ERR;
                    end else if (confirm_pulse) begin
                        rd_idx <= '0;
                        state  <= S_HDR_M;
                    end
                end
                S_HDR_M: state <= tx_busy ? S_HDR_M : S_HDR_N;
                S_HDR_N: state <= tx_busy ? S_HDR_N : S_LOAD;
                S_LOAD:  state <= S_ELEM;
                S_ELEM: begin
                    if (!tx_busy) begin
                        state <= (rd_idx == elem_total) ? S_IDLE : S_LOAD;
                    end
                end
                default: begin
                    // Held in error until the timeout
                end
            endcase
            if (rd_en) begin
                rd_idx <= rd_idx + 1'b1;
            end
        end
    end

    // Outgoing byte and latched slot fields
    always_ff @(posedge clk) begin
        if (state == S_IDLE && confirm_pulse) begin
            tx_byte    <= 8'(query_m);
            n_q        <= query_n;
            base       <= query_addr;
            elem_total <= query_m * query_n;
        end else if (state == S_HDR_M && !tx_busy) begin
            tx_byte <= 8'(n_q);
        end else if (state == S_LOAD) begin
            tx_byte <= 8'(rd_data);
        end
    end

endmodule

// File: src/mode_controller.sv
// =========================================================
// Main mode FSM, active error select and error hold
// countdown timer
// =========================================================
`timescale 1ns/1ps
`include "matrix_calc_defines.svh"

module mode_controller (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   confirm_pulse,
    input  logic                   back_pulse,
    input  logic [2:0]             dip_sw,
    input  matrix_calc_pkg::err_t  entry_err,
    input  matrix_calc_pkg::err_t  readout_err,
    output matrix_calc_pkg::mode_t mode,
    output logic                   error_active,
    output logic [3:0]             countdown,
    output logic                   error_timeout
);

    import matrix_calc_pkg::*;

    localparam int TICK_W = $clog2(`TICKS_PER_SECOND);

    mode_t             mode_next;
    err_t              err_sel;
    logic [TICK_W-1:0] tick_cnt;

    // =========================================================
    // Mode FSM
    // =========================================================
    always_comb begin
        mode_next = mode;
        if (mode == MODE_MENU) begin
            if (confirm_pulse && dip_sw == 3'd1) begin
                mode_next = MODE_ENTRY;
            end else if (confirm_pulse && dip_sw == 3'd2) begin
                mode_next = MODE_READOUT;
            end
        end else if (back_pulse) begin
            mode_next = MODE_MENU;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode <= MODE_MENU;
        end else begin
            mode <= mode_next;
        end
    end

    assign err_sel = (mode == MODE_ENTRY)   ? entry_err :
                     (mode == MODE_READOUT) ? readout_err : ERR_NONE;

    // =========================================================
    // Error hold timer
    // =========================================================
    // Idle for the timeout cycle too, while the erring block returns to idle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tick_cnt      <= '0;
            countdown     <= 4'(`HOLD_SECONDS);
            error_active  <= 1'b0;
            error_timeout <= 1'b0;
        end else if (err_sel == ERR_NONE || error_timeout) begin
            tick_cnt      <= '0;
            countdown     <= 4'(`HOLD_SECONDS);
            error_active  <= 1'b0;
            error_timeout <= 1'b0;
        end else if (tick_cnt == TICK_W'(`TICKS_PER_SECOND - 1)) begin
            tick_cnt <= '0;
            if (countdown == 4'd1) begin
                countdown     <= 4'(`HOLD_SECONDS);
                error_active  <= 1'b0;
                error_timeout <= 1'b1;
            end else begin
                countdown    <= countdown - 4'd1;
                error_active <= 1'b1;
            end
        end else begin
            tick_cnt     <= tick_cnt + 1'b1;
            error_active <= 1'b1;
        end
    end

endmodule

// File: src/status_display.sv
// =========================================================
// Seven-segment and LED status of mode, error, countdown
// =========================================================
`timescale 1ns/1ps

module status_display (
    input  matrix_calc_pkg::mode_t mode,
    input  logic                   error_active,
    input  logic [3:0]             countdown,
    output logic [6:0]             seg_mode,
    output logic [6:0]             seg_countdown,
    output logic [3:0]             led_status
);

    import matrix_calc_pkg::*;

    // Active high segments, bit 0 is segment a
    function automatic logic [6:0] hex_seg(input logic [3:0] digit);
        case (digit)
            4'h0: hex_seg = 7'h3F;
            4'h1: hex_seg = 7'h06;
            4'h2: hex_seg = 7'h5B;
            4'h3: hex_seg = 7'h4F;
            4'h4: hex_seg = 7'h66;
            4'h5: hex_seg = 7'h6D;
            4'h6: hex_seg = 7'h7D;
            4'h7: hex_seg = 7'h07;
            4'h8: hex_seg = 7'h7F;
            4'h9: hex_seg = 7'h6F;
            4'hA: hex_seg = 7'h77;
            4'hB: hex_seg = 7'h7C;
            4'hC: hex_seg = 7'h39;
            4'hD: hex_seg = 7'h5E;
            4'hE: hex_seg = 7'h79;
            default: hex_seg = 7'h71;
        endcase
    endfunction

    assign seg_mode      = error_active ? hex_seg(4'hE) : hex_seg({2'b00, mode});
    assign seg_countdown = hex_seg(countdown);

    assign led_status = {error_active,
                         mode == MODE_READOUT,
                         mode == MODE_ENTRY,
                         mode == MODE_MENU};

endmodule

// File: tests/matrix_calculator_tb.sv
// =========================================================
// Testbench for the matrix store top: navigation, store and
// readback, dimension, value and capacity errors
// =========================================================
`timescale 1ns/1ps
`include "matrix_calc_defines.svh"

module matrix_calculator_tb;

    // Full run is under two thousand cycles
    localparam int CYCLE_LIMIT = 20000;
    localparam int HOLD_LIMIT  = `HOLD_SECONDS * `TICKS_PER_SECOND + 20;
    localparam logic [31:0] SEED = 32'hbe3b_36bc;

    logic       clk;
    logic       rst_n;
    logic [2:0] dip_sw;
    logic       btn_confirm;
    logic       btn_back;
    logic [7:0] rx_data;
    logic       rx_done;
    logic       tx_busy;
    logic [7:0] tx_data;
    logic       tx_start;
    logic [6:0] seg_mode;
    logic [6:0] seg_countdown;
    logic [3:0] led_status;

    int          error_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;
    int          test_errors;
    logic [31:0] busy_state;
    logic [31:0] value_state;
    logic [7:0]  tx_q [$];

    // Reference model of the stored matrices
    int model_m [4];
    int model_n [4];
    int model_elem [4][25];
    int model_count;

    matrix_calculator_top dut (
        .clk, .rst_n, .dip_sw, .btn_confirm, .btn_back,
        .rx_data, .rx_done, .tx_busy, .tx_data, .tx_start,
        .seg_mode, .seg_countdown, .led_status
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Standard hex segment patterns, E shows up as 14
    function automatic int seg_to_digit(input logic [6:0] seg);
        case (seg)
            7'h3F: return 0;
            7'h06: return 1;
            7'h5B: return 2;
            7'h4F: return 3;
            7'h66: return 4;
            7'h6D: return 5;
            7'h7D: return 6;
            7'h07: return 7;
            7'h7F: return 8;
            7'h6F: return 9;
            7'h79: return 14;
            default: return -1;
        endcase
    endfunction

    // Random back-pressure on the byte output
    initial begin
        busy_state = SEED;
        tx_busy    = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            busy_state = lcg_next(busy_state);
            tx_busy    = busy_state[20];
        end
    end

    always @(posedge clk) begin
        if (rst_n && tx_start) begin
            tx_q.push_back(tx_data);
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    tx_start_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !(tx_start && tx_busy))
        else begin
            $display("** Error at %0t: tx_start high while tx_busy high", $time);
            error_count++;
        end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic expect_eq(input int got, input int exp, input string what);
        check_count++;
        assert (got == exp)
            else begin
                $display("** Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
                error_count++;
            end
    endtask

    task automatic press_button(input bit is_confirm);
        step();
        if (is_confirm) btn_confirm = 1'b1;
        else btn_back = 1'b1;
        repeat (10) step();
        btn_confirm = 1'b0;
        btn_back    = 1'b0;
        repeat (10) step();
    endtask

    task automatic enter_mode(input logic [2:0] sel, input logic [3:0] exp_led,
                              input int exp_digit);
        step();
        dip_sw = sel;
        press_button(1'b1);
        expect_eq(led_status, exp_led, "led_status after confirm");
        expect_eq(seg_to_digit(seg_mode), exp_digit, "seg_mode after confirm");
    endtask

    task automatic return_to_menu();
        press_button(1'b0);
        expect_eq(led_status, 4'b0001, "led_status after back");
        expect_eq(seg_to_digit(seg_mode), 0, "seg_mode after back");
    endtask

    task automatic send_byte(input int value);
        step();
        rx_data = 8'(value);
        rx_done = 1'b1;
        step();
        rx_done = 1'b0;
        repeat (2) step();
    endtask

    task automatic store_matrix(input int m, input int n);
        int slot;
        int v;
        slot = model_count;
        send_byte(m);
        send_byte(n);
        for (int i = 0; i < m * n; i++) begin
            value_state = lcg_next(value_state);
            v = int'(value_state[23:12]) % (`MAX_VALUE + 1);
            model_elem[slot][i] = v;
            send_byte(v);
        end
        model_m[slot] = m;
        model_n[slot] = n;
        model_count++;
        repeat (3) step();
        expect_eq(led_status[3], 0, "error LED after store");
    endtask

    task automatic read_slot(input int slot);
        int total;
        int waited;
        int exp;
        total  = 2 + model_m[slot] * model_n[slot];
        waited = 0;
        step();
        dip_sw = 3'(slot);
        tx_q.delete();
        press_button(1'b1);
        while (tx_q.size() < total && waited < 1000) begin
            step();
            waited++;
        end
        repeat (10) step();
        expect_eq(tx_q.size(), total, "readout stream length");
        for (int i = 0; i < total && i < tx_q.size(); i++) begin
            if (i == 0) exp = model_m[slot];
            else if (i == 1) exp = model_n[slot];
            else exp = model_elem[slot][i - 2];
            expect_eq(tx_q[i], exp, $sformatf("slot %0d byte %0d", slot, i));
        end
    endtask

    task automatic wait_error_set();
        int waited;
        waited = 0;
        while (!led_status[3] && waited < 40) begin
            step();
            waited++;
        end
        expect_eq(led_status[3], 1, "error LED raised");
        expect_eq(seg_to_digit(seg_mode), 14, "seg_mode letter E");
    endtask

    // Countdown must start at the hold value and only step down to 1
    task automatic hold_until_clear();
        int digit;
        int prev;
        int cycles;
        prev   = `HOLD_SECONDS;
        cycles = 0;
        expect_eq(seg_to_digit(seg_countdown), `HOLD_SECONDS, "first countdown digit");
        while (led_status[3] && cycles < HOLD_LIMIT) begin
            digit = seg_to_digit(seg_countdown);
            check_count++;
            assert (digit >= 1 && (digit == prev || digit == prev - 1))
                else begin
                    $display("** Error at %0t: countdown %0d after %0d", $time, digit, prev);
                    error_count++;
                end
            prev = digit;
            step();
            cycles++;
        end
        expect_eq(led_status[3], 0, "error LED after hold");
        expect_eq(prev, 1, "last countdown digit");
        step();
        expect_eq(seg_to_digit(seg_countdown), `HOLD_SECONDS, "countdown at rest");
    endtask

    task automatic report_test(input string name);
        $display("%s finished with %0d errors", name, error_count - test_errors);
        test_errors = error_count;
    endtask

    initial begin
        rst_n       = 1'b0;
        dip_sw      = 3'd0;
        btn_confirm = 1'b0;
        btn_back    = 1'b0;
        rx_data     = 8'd0;
        rx_done     = 1'b0;
        value_state = SEED;
        model_count = 0;
        test_errors = 0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (2) step();

        // 1: mode navigation
        expect_eq(led_status, 4'b0001, "led_status after reset");
        enter_mode(3'd1, 4'b0010, 1);
        return_to_menu();
        enter_mode(3'd7, 4'b0001, 0);
        enter_mode(3'd2, 4'b0100, 2);
        return_to_menu();
        report_test("Navigation test");

        // 2: store a 2 by 3 matrix and read it back
        enter_mode(3'd1, 4'b0010, 1);
        store_matrix(2, 3);
        return_to_menu();
        enter_mode(3'd2, 4'b0100, 2);
        read_slot(0);
        return_to_menu();
        report_test("Store and readback test");

        // 3: illegal row count, hold, then a legal matrix
        enter_mode(3'd1, 4'b0010, 1);
        send_byte(`MAX_DIM + 1);
        wait_error_set();
        hold_until_clear();
        store_matrix(3, 2);
        return_to_menu();
        enter_mode(3'd2, 4'b0100, 2);
        read_slot(1);
        return_to_menu();
        report_test("Dimension error test");

        // 4: bad element value, then an empty slot read
        enter_mode(3'd1, 4'b0010, 1);
        send_byte(2);
        send_byte(2);
        send_byte(3);
        send_byte(12);
        wait_error_set();
        hold_until_clear();
        return_to_menu();
        enter_mode(3'd2, 4'b0100, 2);
        step();
        dip_sw = 3'(model_count);
        press_button(1'b1);
        wait_error_set();
        hold_until_clear();
        return_to_menu();
        report_test("Value error test");

        // 5: fill all slots, refuse a fifth, read all four back
        enter_mode(3'd1, 4'b0010, 1);
        store_matrix(2, 2);
        store_matrix(5, 5);
        send_byte(1);
        send_byte(1);
        wait_error_set();
        hold_until_clear();
        return_to_menu();
        enter_mode(3'd2, 4'b0100, 2);
        for (int s = 0; s < `MAX_SLOTS; s++) begin
            read_slot(s);
        end
        return_to_menu();
        report_test("Capacity test");

        $display("Summary: 5 tests, %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
